/* common/noc_flit_pkg.sv */
package noc_flit_pkg;

    // virtual channels per input port
    // the one-hot vc field of a flit is this wide
    localparam int VC_NUM = 4;

    // flit payload width
    localparam int FPAY = 32;

    // head and tail flags
    localparam int HDR_W = 2;

    // flit on the link holds header, one-hot vc field and payload
    localparam int FLIT_W = HDR_W + VC_NUM + FPAY;

    // binary vc index width
    // never below one bit even for a single-vc port
    localparam int VC_IDX_W = (VC_NUM > 1) ? $clog2(VC_NUM) : 1;

    // stored word without the vc field
    localparam int RAM_W = HDR_W + FPAY;

    // header position inside flit_t
    localparam int HDR_LSB = FLIT_W - HDR_W;

    // head and tail flag bits
    typedef logic [HDR_W-1:0] hdr_t;

    // payload bits
    typedef logic [FPAY-1:0] payload_t;

    // one bit per vc for selects and status
    typedef logic [VC_NUM-1:0] vc_mask_t;

    // vc number in binary
    typedef logic [VC_IDX_W-1:0] vc_idx_t;

    // incoming flit laid out as {hdr, vc, payload}
    typedef logic [FLIT_W-1:0] flit_t;

    // buffer word laid out as {hdr, payload}
    typedef logic [RAM_W-1:0] ram_word_t;

endpackage

/* common/input_buffer_pkg.sv */
package input_buffer_pkg;

    // flits per vc, power of two only
    localparam int DEFAULT_DEPTH = 4;

    // speculative switch allocation bypass on by default
    localparam bit DEFAULT_SSA_EN = 1'b1;

    // slot pointer width for the default depth
    localparam int PTR_W = (DEFAULT_DEPTH > 1) ? $clog2(DEFAULT_DEPTH) : 1;

    // per-vc slot pointer
    typedef logic [PTR_W-1:0] buf_ptr_t;

    // per-vc occupancy, one extra bit so a full vc fits
    typedef logic [PTR_W:0] depth_cnt_t;

endpackage

/* hw/input_buffer/vc_ptr_ctrl.sv */
`timescale 1ns/1ps

module vc_ptr_ctrl #(
    parameter int depth = input_buffer_pkg::DEFAULT_DEPTH,
    parameter bit ssa_en = input_buffer_pkg::DEFAULT_SSA_EN,
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1,
    localparam int addr_w = noc_flit_pkg::VC_IDX_W + ptr_w
) (
    input  logic                   clk,
    input  logic                   reset,
    input  noc_flit_pkg::vc_mask_t vc_num_wr,
    input  noc_flit_pkg::vc_mask_t vc_num_rd,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  noc_flit_pkg::vc_mask_t ssa_rd,
    // {vc index, slot pointer}
    output logic [addr_w-1:0]      wr_addr,
    output logic [addr_w-1:0]      rd_addr,
    output noc_flit_pkg::vc_mask_t vc_not_empty
);

    localparam int VC_NUM = noc_flit_pkg::VC_NUM;

    // slot pointer inside one vc slice
    typedef logic [ptr_w-1:0] slot_ptr_t;

    // all pointers of the port, one entry per vc
    typedef slot_ptr_t [VC_NUM-1:0] slot_ptr_vec_t;

    // occupancy, one bit wider than a pointer
    typedef logic [ptr_w:0] occ_t;

    slot_ptr_vec_t wr_ptr;
    slot_ptr_vec_t rd_ptr;
    occ_t          occ [VC_NUM];

    // per-vc push and pop strobes
    noc_flit_pkg::vc_mask_t push;
    noc_flit_pkg::vc_mask_t pop;

    // slot pointers of the selected vcs
    slot_ptr_t wr_slot;
    slot_ptr_t rd_slot;

    // slice index of the selected vcs
    noc_flit_pkg::vc_idx_t wr_vc_idx;
    noc_flit_pkg::vc_idx_t rd_vc_idx;

    // and-or mux over the per-vc pointers
    function automatic slot_ptr_t onehot_ptr_mux(
        input slot_ptr_vec_t          ptrs,
        input noc_flit_pkg::vc_mask_t sel
    );
        slot_ptr_t res;
        res = '0;
        for (int i = 0; i < VC_NUM; i++) begin
            if (sel[i]) begin
                res = res | ptrs[i];
            end
        end
        return res;
    endfunction

    // one-hot to binary, or of the set positions
    function automatic noc_flit_pkg::vc_idx_t onehot_to_bin(
        input noc_flit_pkg::vc_mask_t sel
    );
        noc_flit_pkg::vc_idx_t res;
        res = '0;
        for (int i = 0; i < VC_NUM; i++) begin
            if (sel[i]) begin
                res = res | noc_flit_pkg::vc_idx_t'(i);
            end
        end
        return res;
    endfunction

    // a write pushes into the selected vc
    assign push = wr_en ? vc_num_wr : '0;

    // normal read has priority, speculative pops only in idle read cycles
    assign pop = rd_en ? vc_num_rd : (ssa_en ? ssa_rd : '0);

    genvar i;
    generate
        for (i = 0; i < VC_NUM; i++) begin : g_vc
            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    wr_ptr[i] <= '0;
                    rd_ptr[i] <= '0;
                    occ[i] <= '0;
                end else begin
                    // pointers wrap inside the slice, depth is a power of two
                    if (push[i]) begin
                        wr_ptr[i] <= wr_ptr[i] + 1'b1;
                    end
                    if (pop[i]) begin
                        rd_ptr[i] <= rd_ptr[i] + 1'b1;
                    end
                    // push and pop together leave the count alone
                    if (push[i] && !pop[i]) begin
                        occ[i] <= occ[i] + 1'b1;
                    end else if (!push[i] && pop[i]) begin
                        occ[i] <= occ[i] - 1'b1;
                    end
                end
            end

            // status straight from the registered count
            assign vc_not_empty[i] = (occ[i] != '0);
        end
    endgenerate

    // pointer of the vc being written
    assign wr_slot = onehot_ptr_mux(wr_ptr, vc_num_wr);

    // pointer of the vc being read
    assign rd_slot = onehot_ptr_mux(rd_ptr, vc_num_rd);

    // slice base in binary
    assign wr_vc_idx = onehot_to_bin(vc_num_wr);
    assign rd_vc_idx = onehot_to_bin(vc_num_rd);

    // vc index picks the slice, pointer picks the slot
    assign wr_addr = {wr_vc_idx, wr_slot};
    assign rd_addr = {rd_vc_idx, rd_slot};

endmodule

/* hw/input_buffer/flit_ram.sv */
`timescale 1ns/1ps

module flit_ram #(
    parameter int depth = input_buffer_pkg::DEFAULT_DEPTH,
    parameter bit ssa_en = input_buffer_pkg::DEFAULT_SSA_EN,
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1,
    localparam int addr_w = noc_flit_pkg::VC_IDX_W + ptr_w
) (
    input  logic                    clk,
    input  noc_flit_pkg::ram_word_t ram_wr_data,
    input  logic [addr_w-1:0]       wr_addr,
    input  logic [addr_w-1:0]       rd_addr,
    input  logic                    wr_en,
    input  logic                    rd_en,
    output noc_flit_pkg::ram_word_t rd_data
);

    // one slice of 2**ptr_w words per vc
    localparam int WORDS = noc_flit_pkg::VC_NUM * (2 ** ptr_w);

    noc_flit_pkg::ram_word_t mem [WORDS];

    // registered read port
    noc_flit_pkg::ram_word_t mem_rd_data;

    // simple dual port, write and read in the same edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= ram_wr_data;
        end
        // holds the last read word while rd_en is low
        if (rd_en) begin
            mem_rd_data <= mem[rd_addr];
        end
    end

    generate
        if (ssa_en) begin : g_ssa
            // last write data, offered when no read was issued
            noc_flit_pkg::ram_word_t bypass_q;
            logic                    rd_en_q;

            always_ff @(posedge clk) begin
                bypass_q <= ram_wr_data;
                rd_en_q <= rd_en;
            end

            // read result after a read cycle, bypassed flit otherwise
            assign rd_data = rd_en_q ? mem_rd_data : bypass_q;
        end else begin : g_no_ssa
            assign rd_data = mem_rd_data;
        end
    endgenerate

endmodule

/* hw/input_buffer/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer #(
    parameter int depth = input_buffer_pkg::DEFAULT_DEPTH,
    parameter bit ssa_en = input_buffer_pkg::DEFAULT_SSA_EN,
    // slot pointer and ram address widths follow depth
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1,
    localparam int addr_w = noc_flit_pkg::VC_IDX_W + ptr_w
) (
    input  logic                   clk,
    input  logic                   reset,
    // flit from the upstream link
    input  noc_flit_pkg::flit_t    din,
    input  noc_flit_pkg::vc_mask_t vc_num_wr,
    input  noc_flit_pkg::vc_mask_t vc_num_rd,
    input  logic                   wr_en,
    input  logic                   rd_en,
    // speculative pops from switch allocation
    input  noc_flit_pkg::vc_mask_t ssa_rd,
    output noc_flit_pkg::ram_word_t dout,
    output noc_flit_pkg::vc_mask_t vc_not_empty
);

    // incoming flit split into its stored fields
    noc_flit_pkg::hdr_t      hdr_in;
    noc_flit_pkg::payload_t  payload_in;
    noc_flit_pkg::ram_word_t ram_wr_data;

    // ram addresses from pointer control
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;

    // header sits at the top of the flit
    assign hdr_in = din[noc_flit_pkg::HDR_LSB +: noc_flit_pkg::HDR_W];

    // payload at the bottom
    assign payload_in = din[noc_flit_pkg::FPAY-1:0];

    // vc field dropped, the slice address already says which vc
    assign ram_wr_data = {hdr_in, payload_in};

    // per-vc pointers and occupancy
    vc_ptr_ctrl #(
        .depth  (depth),
        .ssa_en (ssa_en)
    ) u_ptr (
        .clk          (clk),
        .reset        (reset),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .ssa_rd       (ssa_rd),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // shared storage for all vcs of the port
    flit_ram #(
        .depth  (depth),
        .ssa_en (ssa_en)
    ) u_ram (
        .clk         (clk),
        .ram_wr_data (ram_wr_data),
        .wr_addr     (wr_addr),
        .rd_addr     (rd_addr),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .rd_data     (dout)
    );

endmodule

/* verif/buffer_checker.sv */
`timescale 1ns/1ps

module buffer_checker #(
    parameter int depth = 4,
    parameter bit ssa_en = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  noc_flit_pkg::flit_t     din,
    input  noc_flit_pkg::vc_mask_t  vc_num_wr,
    input  noc_flit_pkg::vc_mask_t  vc_num_rd,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  noc_flit_pkg::vc_mask_t  ssa_rd,
    input  noc_flit_pkg::ram_word_t dout,
    input  noc_flit_pkg::vc_mask_t  vc_not_empty,
    // number of the running test, negative after the last one
    input  int                      test_num,
    output int                      check_count,
    output int                      error_count
);

    localparam int VC_NUM = noc_flit_pkg::VC_NUM;
    localparam int QLEN = 4 * depth;

    // one circular reference queue per vc
    noc_flit_pkg::ram_word_t ref_q [VC_NUM][QLEN];
    int                      q_head [VC_NUM];
    int                      q_cnt [VC_NUM];

    // dout expected after the last edge
    noc_flit_pkg::ram_word_t exp_dout;
    logic                    exp_dout_valid;

    // set from the first edge that sees reset low
    logic                    model_live;

    int last_test;
    int test_checks;
    int test_errors;

    // header over payload with the vc field removed
    function automatic noc_flit_pkg::ram_word_t expected_word(input noc_flit_pkg::flit_t f);
        return {f[noc_flit_pkg::FLIT_W-1 -: 2], f[noc_flit_pkg::FPAY-1:0]};
    endfunction

    // lowest set bit of a one-hot select
    function automatic int vc_index(input noc_flit_pkg::vc_mask_t m);
        int idx;
        idx = 0;
        for (int v = VC_NUM - 1; v >= 0; v--) begin
            if (m[v]) begin
                idx = v;
            end
        end
        return idx;
    endfunction

    task automatic push_word(input int v, input noc_flit_pkg::ram_word_t w);
        ref_q[v][(q_head[v] + q_cnt[v]) % QLEN] = w;
        q_cnt[v]++;
    endtask

    // takes the oldest entry of a vc
    // an empty queue here means broken stimulus
    task automatic pop_word(input int v, output noc_flit_pkg::ram_word_t w);
        w = ref_q[v][q_head[v]];
        if (q_cnt[v] == 0) begin
            $display("pop from empty vc %0d at %0t ns, stimulus is broken", v, $time);
            error_count++;
            test_errors++;
        end else begin
            q_head[v] = (q_head[v] + 1) % QLEN;
            q_cnt[v]--;
        end
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        last_test = 0;
        exp_dout_valid = 1'b0;
        model_live = 1'b0;
    end

    // model update from the inputs sampled at the edge
    always @(posedge clk) begin
        noc_flit_pkg::ram_word_t w;
        exp_dout_valid = 1'b0;
        model_live = !reset;
        if (reset) begin
            for (int v = 0; v < VC_NUM; v++) begin
                q_head[v] = 0;
                q_cnt[v] = 0;
            end
        end else if (rd_en) begin
            // oldest flit leaves before the new one lands
            pop_word(vc_index(vc_num_rd), w);
            exp_dout = w;
            exp_dout_valid = 1'b1;
            if (wr_en) begin
                push_word(vc_index(vc_num_wr), expected_word(din));
            end
        end else begin
            if (wr_en) begin
                push_word(vc_index(vc_num_wr), expected_word(din));
            end
            // speculative pops count only when no read is issued
            for (int v = 0; v < VC_NUM; v++) begin
                if (ssa_en && ssa_rd[v]) begin
                    pop_word(v, w);
                    exp_dout = w;
                    exp_dout_valid = 1'b1;
                end
            end
        end
        if (test_num != last_test) begin
            if (last_test > 0) begin
                $display("test %0d done: %0d checks, %0d errors",
                         last_test, test_checks, test_errors);
            end
            test_checks = 0;
            test_errors = 0;
            last_test = test_num;
        end
    end

    // registered outputs are stable by the falling edge
    always @(negedge clk) begin
        noc_flit_pkg::vc_mask_t exp_ne;
        if (model_live) begin
            for (int v = 0; v < VC_NUM; v++) begin
                exp_ne[v] = (q_cnt[v] != 0);
            end
            check_count++;
            test_checks++;
            if (vc_not_empty !== exp_ne) begin
                $display("error at %0t ns: vc_not_empty expected %b actual %b",
                         $time, exp_ne, vc_not_empty);
                error_count++;
                test_errors++;
            end
            if (exp_dout_valid) begin
                check_count++;
                test_checks++;
                if (dout !== exp_dout) begin
                    $display("error at %0t ns: dout expected %h actual %h",
                             $time, exp_dout, dout);
                    error_count++;
                    test_errors++;
                end
            end
        end
    end

endmodule

/* verif/tb_input_buffer.sv */
`timescale 1ns/1ps

module tb_input_buffer;

    localparam int DEPTH = 4;
    localparam bit SSA_EN = 1'b1;
    localparam int VC_NUM = noc_flit_pkg::VC_NUM;
    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_CYCLES = 400;
    // worst case length of all tests, plus slack for the watchdog
    localparam int TEST_CYCLES = RESET_CYCLES + RAND_CYCLES + 6 * DEPTH * VC_NUM + 40;
    localparam int MARGIN_CYCLES = 200;

    logic                    clk;
    logic                    reset;
    noc_flit_pkg::flit_t     din;
    noc_flit_pkg::vc_mask_t  vc_num_wr;
    noc_flit_pkg::vc_mask_t  vc_num_rd;
    logic                    wr_en;
    logic                    rd_en;
    noc_flit_pkg::vc_mask_t  ssa_rd;
    noc_flit_pkg::ram_word_t dout;
    noc_flit_pkg::vc_mask_t  vc_not_empty;

    int          test_num;
    int          check_count;
    int          error_count;
    logic [15:0] lfsr_state;
    // stimulus-side occupancy, keeps every vc legal
    int          occ [VC_NUM];

    input_buffer #(
        .depth  (DEPTH),
        .ssa_en (SSA_EN)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .ssa_rd       (ssa_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    buffer_checker #(
        .depth  (DEPTH),
        .ssa_en (SSA_EN)
    ) chk0 (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .ssa_rd       (ssa_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty),
        .test_num     (test_num),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[62:0], lfsr_state[0]};
        end
    endtask

    // random header and payload, vc field set to the target vc
    task automatic make_flit(input int v, output noc_flit_pkg::flit_t f);
        logic [63:0] hdr;
        logic [63:0] pay;
        take_bits(2, hdr);
        take_bits(noc_flit_pkg::FPAY, pay);
        f = {hdr[1:0], noc_flit_pkg::vc_mask_t'(1) << v, pay[noc_flit_pkg::FPAY-1:0]};
    endtask

    // one clock cycle of stimulus, driven on the falling edge
    task automatic step(input logic wr, input int wv, input noc_flit_pkg::flit_t f,
                        input logic rd, input int rv, input noc_flit_pkg::vc_mask_t ssa);
        @(negedge clk);
        wr_en = wr;
        vc_num_wr = wr ? noc_flit_pkg::vc_mask_t'(1) << wv : '0;
        din = f;
        rd_en = rd;
        vc_num_rd = rd ? noc_flit_pkg::vc_mask_t'(1) << rv : '0;
        ssa_rd = ssa;
        if (rd) begin
            occ[rv]--;
        end else begin
            for (int v = 0; v < VC_NUM; v++) begin
                if (SSA_EN && ssa[v]) begin
                    occ[v]--;
                end
            end
        end
        if (wr) begin
            occ[wv]++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, 0, '0, 1'b0, 0, '0);
    endtask

    task automatic drain_all();
        for (int v = 0; v < VC_NUM; v++) begin
            while (occ[v] > 0) begin
                step(1'b0, 0, '0, 1'b1, v, '0);
            end
        end
    endtask

    // random mix of writes and reads over all vcs
    task automatic random_traffic(input int cycles);
        logic [63:0]         b;
        logic                wr;
        logic                rd;
        int                  wv;
        int                  rv;
        noc_flit_pkg::flit_t f;
        noc_flit_pkg::vc_mask_t ssa;
        for (int c = 0; c < cycles; c++) begin
            take_bits(1, b);
            wr = b[0];
            take_bits(noc_flit_pkg::VC_IDX_W, b);
            wv = int'(b) % VC_NUM;
            take_bits(1, b);
            rd = b[0];
            take_bits(noc_flit_pkg::VC_IDX_W, b);
            rv = int'(b) % VC_NUM;
            // no write into a full vc, no read from an empty one
            if (occ[wv] >= DEPTH) wr = 1'b0;
            if (occ[rv] == 0) rd = 1'b0;
            make_flit(wv, f);
            // ssa strobes under a read must be ignored
            ssa = '0;
            if (rd) begin
                take_bits(VC_NUM, b);
                ssa = b[VC_NUM-1:0];
            end
            step(wr, wv, f, rd, rv, ssa);
        end
    endtask

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("timeout: tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        noc_flit_pkg::flit_t f;
        reset = 1'b1;
        din = '0;
        vc_num_wr = '0;
        vc_num_rd = '0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        ssa_rd = '0;
        test_num = 0;
        lfsr_state = 16'd38898;
        for (int v = 0; v < VC_NUM; v++) begin
            occ[v] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // status clear after reset
        test_num = 1;
        idle(3);

        // fill one vc, then read it back in order
        test_num = 2;
        for (int i = 0; i < DEPTH; i++) begin
            make_flit(2, f);
            step(1'b1, 2, f, 1'b0, 0, '0);
        end
        drain_all();
        idle(2);

        test_num = 3;
        random_traffic(RAND_CYCLES);
        drain_all();
        idle(2);

        // write and read on the same busy vc in one cycle
        test_num = 4;
        for (int i = 0; i < 2; i++) begin
            make_flit(1, f);
            step(1'b1, 1, f, 1'b0, 0, '0);
        end
        make_flit(1, f);
        step(1'b1, 1, f, 1'b1, 1, '0);
        drain_all();
        idle(2);

        // speculative pop of a flit written into an empty vc
        test_num = 5;
        for (int v = 0; v < VC_NUM; v++) begin
            make_flit(v, f);
            step(1'b1, v, f, 1'b0, 0, noc_flit_pkg::vc_mask_t'(1) << v);
            idle(1);
        end
        idle(1);

        test_num = -1;
        repeat (2) @(negedge clk);
        $display("5 tests, %0d checks, %0d errors", check_count, error_count);
        if (check_count == 0) begin
            $display("no output of the buffer was ever checked");
        end
        if (error_count == 0 && check_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
common/noc_flit_pkg.sv
common/input_buffer_pkg.sv
hw/input_buffer/vc_ptr_ctrl.sv
hw/input_buffer/flit_ram.sv
hw/input_buffer/input_buffer.sv
verif/buffer_checker.sv
verif/tb_input_buffer.sv

/* Bender.yml */
package:
  name: input_buffer

sources:
  - common/noc_flit_pkg.sv
  - common/input_buffer_pkg.sv
  - hw/input_buffer/vc_ptr_ctrl.sv
  - hw/input_buffer/flit_ram.sv
  - hw/input_buffer/input_buffer.sv
  - target: simulation
    files:
      - verif/buffer_checker.sv
      - verif/tb_input_buffer.sv
